/* include/shift_unit_consts.svh */
//------------------------------------------------------------
// Width, count and flag position constants for the shifter
// Reset value of the architectural flags register
//------------------------------------------------------------
`ifndef SHIFT_UNIT_CONSTS_SVH
`define SHIFT_UNIT_CONSTS_SVH

// Operand and result width
`define SHIFT_DATA_W 32

// Only the low count bits take part in the shift
`define SHIFT_CNT_W 5

// Bit positions inside the flags word
`define FLAG_CF 0
`define FLAG_PF 2
`define FLAG_AF 4
`define FLAG_ZF 6
`define FLAG_SF 7
`define FLAG_DF 10
`define FLAG_OF 11

// Reserved bit 1 always reads as one
`define EFLAGS_RESET 32'h0000_0002

`endif

/* rtl/barrel_shift_left.sv */
//------------------------------------------------------------
// Logarithmic left shifter with carry out
//------------------------------------------------------------
`timescale 1ns/1ps
`include "shift_unit_consts.svh"

module barrel_shift_left (
	input  logic [`SHIFT_DATA_W-1:0] value,
	input  logic [`SHIFT_CNT_W-1:0]  amount,
	output logic [`SHIFT_DATA_W-1:0] shifted,
	output logic                     carry
);

	// One extra bit on top catches the last bit shifted out
	logic [`SHIFT_DATA_W:0] stage [0:`SHIFT_CNT_W];

	// Carry slot starts empty
	assign stage[0] = {1'b0, value};

	//------------------------------------------------------------
	// Five conditional stages, 1 2 4 8 16
	//------------------------------------------------------------
	genvar i;
	generate
		for (i = 0; i < `SHIFT_CNT_W; i++) begin : g_stage
			localparam int STEP = 1 << i;

			// Zeros enter from the bottom
			// bits above the carry slot fall off
			assign stage[i+1] = amount[i] ?
				{stage[i][`SHIFT_DATA_W-STEP:0], {STEP{1'b0}}} :
				stage[i];
		end
	endgenerate

	// Top slot now holds value bit (32 - amount)
	// and stays 0 for a zero amount
	assign carry   = stage[`SHIFT_CNT_W][`SHIFT_DATA_W];
	assign shifted = stage[`SHIFT_CNT_W][`SHIFT_DATA_W-1:0];

endmodule

/* rtl/barrel_shift_right_arith.sv */
//------------------------------------------------------------
// Logarithmic arithmetic right shifter with carry out
//------------------------------------------------------------
`timescale 1ns/1ps
`include "shift_unit_consts.svh"

module barrel_shift_right_arith (
	input  logic [`SHIFT_DATA_W-1:0] value,
	input  logic [`SHIFT_CNT_W-1:0]  amount,
	output logic [`SHIFT_DATA_W-1:0] shifted,
	output logic                     carry
);

	// Extra bit below bit 0 catches the last bit shifted out
	logic [`SHIFT_DATA_W:0] stage [0:`SHIFT_CNT_W];

	assign stage[0] = {value, 1'b0};

	//------------------------------------------------------------
	// Five conditional stages with sign fill
	//------------------------------------------------------------
	genvar i;
	generate
		for (i = 0; i < `SHIFT_CNT_W; i++) begin : g_stage
			localparam int STEP = 1 << i;

			// Top bit is still the original sign at every stage
			assign stage[i+1] = amount[i] ?
				{{STEP{stage[i][`SHIFT_DATA_W]}}, stage[i][`SHIFT_DATA_W:STEP]} :
				stage[i];
		end
	endgenerate

	// Low slot holds value bit (amount - 1)
	// zero amount leaves the initial 0 there
	assign carry   = stage[`SHIFT_CNT_W][0];
	assign shifted = stage[`SHIFT_CNT_W][`SHIFT_DATA_W:1];

endmodule

/* rtl/shift_exec_stage.sv */
//------------------------------------------------------------
// Execute stage shift unit top with result register
// Architectural flags register with masked merge
//------------------------------------------------------------
`timescale 1ns/1ps
`include "shift_unit_consts.svh"

module shift_exec_stage
	import shift_pkg::*;
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     in_valid,
	input  shift_dir_t               shift_dir,
	input  logic [`SHIFT_DATA_W-1:0] operand,
	input  logic [`SHIFT_DATA_W-1:0] count,
	output logic                     out_valid,
	output logic [`SHIFT_DATA_W-1:0] shift_result,
	output logic [`SHIFT_DATA_W-1:0] eflags
);

	logic [`SHIFT_DATA_W-1:0] core_result;
	eflags_u                  core_flags;
	logic [`SHIFT_DATA_W-1:0] core_mask;
	logic [`SHIFT_DATA_W-1:0] eflags_merged;

	// Shift core, no state
	shifter32 u_core (
		.shift_dir    (shift_dir),
		.operand      (operand),
		.count        (count),
		.shift_result (core_result),
		.shift_flags  (core_flags),
		.flag_mask    (core_mask)
	);

	// Masked bits take the new value, the rest keep the old one
	assign eflags_merged = (eflags & ~core_mask) | (core_flags.raw & core_mask);

	//------------------------------------------------------------
	// Output and flags registers, one cycle latency
	//------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid    <= 1'b0;
			shift_result <= '0;
			eflags       <= `EFLAGS_RESET;
		end else begin
			out_valid <= in_valid;
			if (in_valid) begin
				shift_result <= core_result;
				eflags       <= eflags_merged;
			end
		end
	end

	//------------------------------------------------------------
	// Timing checks
	//------------------------------------------------------------
	// Fixed one cycle latency, no bubbles and no extra outputs
	a_valid_follows: assert property (@(posedge clk) disable iff (reset)
		in_valid |=> out_valid);
	a_no_spurious: assert property (@(posedge clk) disable iff (reset)
		!in_valid |=> !out_valid);

	// Reserved bit 1 survives every merge
	a_rsvd_bit1: assert property (@(posedge clk) disable iff (reset)
		eflags[1]);

	// Flags only move on a strobe
	a_flags_hold: assert property (@(posedge clk) disable iff (reset)
		!in_valid |=> $stable(eflags));

endmodule

/* rtl/shift_flag_logic.sv */
//------------------------------------------------------------
// Flag values and flag write mask for SAL and SAR
//------------------------------------------------------------
`timescale 1ns/1ps
`include "shift_unit_consts.svh"

module shift_flag_logic
	import shift_pkg::*;
(
	input  shift_dir_t               dir,
	input  logic [`SHIFT_CNT_W-1:0]  amount,
	input  logic [`SHIFT_DATA_W-1:0] result,
	input  logic                     carry,
	output eflags_u                  flags,
	output logic [`SHIFT_DATA_W-1:0] mask
);

	// Flags a nonzero shift is allowed to write
	logic [`SHIFT_DATA_W-1:0] writable;
	// Mask seen through the named flags layout
	eflags_u                  mask_view;

	//------------------------------------------------------------
	// Flag values
	//------------------------------------------------------------
	always_comb begin
		flags.raw     = '0;
		flags.bits.cf = carry;
		// Parity is even parity of the low byte only
		flags.bits.pf = ~^result[7:0];
		// AF undefined for shifts, written as 0
		flags.bits.af = 1'b0;
		flags.bits.zf = (result == '0);
		flags.bits.sf = result[`SHIFT_DATA_W-1];
		flags.bits.df = 1'b0;
		// SAR by one always clears OF
		if (dir == SHIFT_LEFT)
			flags.bits.of = result[`SHIFT_DATA_W-1] ^ carry;
		else
			flags.bits.of = 1'b0;
	end

	//------------------------------------------------------------
	// Write mask
	//------------------------------------------------------------
	always_comb begin
		writable           = '0;
		writable[`FLAG_CF] = 1'b1;
		writable[`FLAG_PF] = 1'b1;
		writable[`FLAG_AF] = 1'b1;
		writable[`FLAG_ZF] = 1'b1;
		writable[`FLAG_SF] = 1'b1;
		// OF only defined for a count of one
		writable[`FLAG_OF] = (amount == `SHIFT_CNT_W'd1);
		// Zero count leaves every flag alone
		mask = (amount == '0) ? '0 : writable;
	end

	assign mask_view.raw = mask;

	// DF and reserved positions must never reach the flags register
	// Bit positions are checked against the named layout of the word
	always_comb begin
		assert ((mask_view.bits.df == 1'b0) && (mask_view.bits.rsvd_31_12 == '0) &&
			(mask_view.bits.rsvd_9_8 == '0) && (mask_view.bits.rsvd_5 == 1'b0) &&
			(mask_view.bits.rsvd_3 == 1'b0) && (mask_view.bits.rsvd_1 == 1'b0))
			else $error("flag mask writes DF or a reserved bit, mask %h", mask);
	end

endmodule

/* rtl/shift_pkg.sv */
//------------------------------------------------------------
// Shift direction type and flags word views
//------------------------------------------------------------
`include "shift_unit_consts.svh"

package shift_pkg;

	// Direction select, matches the opcode bit from decode
	typedef enum logic {
		SHIFT_LEFT  = 1'b0,
		SHIFT_RIGHT = 1'b1
	} shift_dir_t;

	// Named view of the flags word, MSB first
	typedef struct packed {
		logic [19:0] rsvd_31_12;
		logic        of;
		logic        df;
		// TF and IF are not touched by this unit
		logic [1:0]  rsvd_9_8;
		logic        sf;
		logic        zf;
		logic        rsvd_5;
		logic        af;
		logic        rsvd_3;
		logic        pf;
		logic        rsvd_1;
		logic        cf;
	} eflags_bits_t;

	// Same word seen raw for the masked merge, or by flag name
	typedef union packed {
		logic [`SHIFT_DATA_W-1:0] raw;
		eflags_bits_t             bits;
	} eflags_u;

endpackage

/* rtl/shifter32.sv */
//------------------------------------------------------------
// Combinational SAL / SAR core with flag generation
//------------------------------------------------------------
`timescale 1ns/1ps
`include "shift_unit_consts.svh"

module shifter32
	import shift_pkg::*;
(
	input  shift_dir_t               shift_dir,
	input  logic [`SHIFT_DATA_W-1:0] operand,
	input  logic [`SHIFT_DATA_W-1:0] count,
	output logic [`SHIFT_DATA_W-1:0] shift_result,
	output eflags_u                  shift_flags,
	output logic [`SHIFT_DATA_W-1:0] flag_mask
);

	// x86 masks the count to five bits
	logic [`SHIFT_CNT_W-1:0]  amount;
	logic [`SHIFT_DATA_W-1:0] left_result;
	logic [`SHIFT_DATA_W-1:0] right_result;
	logic                     left_carry;
	logic                     right_carry;
	logic                     sel_carry;

	assign amount = count[`SHIFT_CNT_W-1:0];

	//------------------------------------------------------------
	// Both directions run in parallel
	//------------------------------------------------------------
	barrel_shift_left u_sal (
		.value   (operand),
		.amount  (amount),
		.shifted (left_result),
		.carry   (left_carry)
	);

	barrel_shift_right_arith u_sar (
		.value   (operand),
		.amount  (amount),
		.shifted (right_result),
		.carry   (right_carry)
	);

	// Direction pick, one flag block after the select
	assign shift_result = (shift_dir == SHIFT_RIGHT) ? right_result : left_result;
	assign sel_carry    = (shift_dir == SHIFT_RIGHT) ? right_carry : left_carry;

	shift_flag_logic u_flags (
		.dir    (shift_dir),
		.amount (amount),
		.result (shift_result),
		.carry  (sel_carry),
		.flags  (shift_flags),
		.mask   (flag_mask)
	);

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the shift unit testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir &&
verilator --binary --timing --top-module shift_exec_stage_tb \
	-Mdir obj_dir -f shift_exec_stage.f || { echo "run_sim: build failed"; exit 1; }
sim_out=$(./obj_dir/Vshift_exec_stage_tb 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -q -F '*** PASSED ***' &&
	echo "run_sim: pass" ||
	{ echo "run_sim: fail"; exit 1; }

/* shift_exec_stage.f */
+incdir+include
rtl/shift_pkg.sv
rtl/barrel_shift_left.sv
rtl/barrel_shift_right_arith.sv
rtl/shift_flag_logic.sv
rtl/shifter32.sv
rtl/shift_exec_stage.sv
sim/shift_exec_stage_tb.sv

/* sim/shift_exec_stage_tb.sv */
//------------------------------------------------------------
// Testbench for the SAL / SAR execute stage
// Random and directed stimulus, reference model, checker
//------------------------------------------------------------
`timescale 1ns/1ps
`include "shift_unit_consts.svh"

module shift_exec_stage_tb
	import shift_pkg::*;
();

	// Operation count fixes the timeout
	localparam int TOTAL_OPS      = 125;
	localparam int TIMEOUT_CYCLES = 4 * TOTAL_OPS + 100;

	logic        clk;
	logic        reset;
	logic        in_valid;
	shift_dir_t  shift_dir;
	logic [31:0] operand;
	logic [31:0] count;
	logic        out_valid;
	logic [31:0] shift_result;
	logic [31:0] eflags;

	// Expected {result, flags} pairs in issue order
	logic [63:0] exp_q [$];
	logic [63:0] exp_pair;
	logic [31:0] exp_flags;
	logic [31:0] rng_state;
	int          issued_cnt;
	int          checked_cnt;
	int          cycle_cnt = 0;

	shift_exec_stage DUT (
		.clk          (clk),
		.reset        (reset),
		.in_valid     (in_valid),
		.shift_dir    (shift_dir),
		.operand      (operand),
		.count        (count),
		.out_valid    (out_valid),
		.shift_result (shift_result),
		.eflags       (eflags)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//------------------------------------------------------------
	// Helpers and reference model
	//------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// x86 SAL / SAR semantics, count masked to five bits
	function automatic logic [63:0] shift_ref(input shift_dir_t dir, input logic [31:0] opnd,
			input logic [31:0] cnt, input logic [31:0] prev_flags);
		int          amt;
		logic [31:0] res;
		logic        cf;
		logic [31:0] flags;
		amt   = int'(cnt[4:0]);
		flags = prev_flags;
		cf    = 1'b0;
		if (dir == SHIFT_LEFT) begin
			res = opnd << amt;
			if (amt != 0)
				cf = opnd[32 - amt];
		end else begin
			res = $signed(opnd) >>> amt;
			if (amt != 0)
				cf = opnd[amt - 1];
		end
		// Zero count keeps every flag
		if (amt != 0) begin
			flags[`FLAG_CF] = cf;
			flags[`FLAG_PF] = ~^res[7:0];
			flags[`FLAG_AF] = 1'b0;
			flags[`FLAG_ZF] = (res == 32'h0);
			flags[`FLAG_SF] = res[31];
			// OF only defined for a single bit shift
			if (amt == 1)
				flags[`FLAG_OF] = (dir == SHIFT_LEFT) ? (res[31] ^ cf) : 1'b0;
		end
		return {res, flags};
	endfunction

	task automatic fail_and_stop(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped on error");
	endtask

	// Drive one strobe, record what should come back
	task automatic issue_op(input shift_dir_t dir, input logic [31:0] opnd,
			input logic [31:0] cnt);
		logic [63:0] ref_pair;
		ref_pair  = shift_ref(dir, opnd, cnt, exp_flags);
		exp_flags = ref_pair[31:0];
		exp_q.push_back(ref_pair);
		in_valid  = 1'b1;
		shift_dir = dir;
		operand   = opnd;
		count     = cnt;
		issued_cnt++;
		@(posedge clk);
		#2;
		in_valid = 1'b0;
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		#2;
	endtask

	//------------------------------------------------------------
	// Checker, samples on the falling edge
	//------------------------------------------------------------
	always @(negedge clk) begin
		if (!reset && out_valid) begin
			assert (exp_q.size() != 0)
				else fail_and_stop("out_valid came with no operation outstanding");
			exp_pair = exp_q.pop_front();
			assert (shift_result == exp_pair[63:32])
				else fail_and_stop($sformatf("error shift_result got %h expected %h",
					shift_result, exp_pair[63:32]));
			assert (eflags == exp_pair[31:0])
				else fail_and_stop($sformatf("error eflags got %h expected %h",
					eflags, exp_pair[31:0]));
			checked_cnt++;
		end
	end

	// Watchdog
	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	initial begin
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("timeout, not all operations came back in time");
		$display("*** FAILED ***");
		$fatal(1, "timeout");
	end

	//------------------------------------------------------------
	// Stimulus
	//------------------------------------------------------------
	initial begin
		reset       = 1'b1;
		in_valid    = 1'b0;
		shift_dir   = SHIFT_LEFT;
		operand     = 32'h0;
		count       = 32'h0;
		exp_flags   = `EFLAGS_RESET;
		rng_state   = 32'hb827;
		issued_cnt  = 0;
		checked_cnt = 0;
		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;
		idle_cycle();
		// Idle state after reset
		assert (out_valid == 1'b0)
			else fail_and_stop($sformatf("error out_valid got %h expected 0", out_valid));
		assert (eflags == `EFLAGS_RESET)
			else fail_and_stop($sformatf("error eflags got %h expected %h",
				eflags, `EFLAGS_RESET));

		// Random SAL, every fourth count uses all 32 bits
		for (int i = 0; i < 48; i++) begin
			rng_state = xorshift32(rng_state);
			operand   = rng_state;
			rng_state = xorshift32(rng_state);
			issue_op(SHIFT_LEFT, operand, (i % 4 == 0) ? rng_state : {27'h0, rng_state[4:0]});
			if (rng_state[8])
				idle_cycle();
		end
		issue_op(SHIFT_LEFT, 32'h0000_0003, 32'd31);
		issue_op(SHIFT_LEFT, 32'hffff_fffe, 32'd31);

		// Random SAR, sign alternates
		for (int i = 0; i < 48; i++) begin
			rng_state = xorshift32(rng_state);
			operand   = i[0] ? (rng_state | 32'h8000_0000) : (rng_state & 32'h7fff_ffff);
			rng_state = xorshift32(rng_state);
			issue_op(SHIFT_RIGHT, operand, {27'h0, rng_state[4:0]});
			if (rng_state[9])
				idle_cycle();
		end
		issue_op(SHIFT_RIGHT, 32'h8000_0001, 32'd31);
		issue_op(SHIFT_RIGHT, 32'h7fff_ffff, 32'd31);

		// Counts with zero low bits change nothing
		issue_op(SHIFT_LEFT, 32'h1234_5678, 32'd0);
		issue_op(SHIFT_RIGHT, 32'h8765_4321, 32'd32);
		issue_op(SHIFT_LEFT, 32'hdead_beef, 32'd64);

		// OF written only by count one
		issue_op(SHIFT_LEFT, 32'h4000_0000, 32'd1);
		issue_op(SHIFT_LEFT, 32'h0000_0001, 32'd3);
		issue_op(SHIFT_LEFT, 32'h0000_0001, 32'd1);
		issue_op(SHIFT_RIGHT, 32'hc000_0000, 32'd5);
		issue_op(SHIFT_LEFT, 32'h4000_0000, 32'd1);
		issue_op(SHIFT_RIGHT, 32'h8000_0000, 32'd1);

		// Back to back strobes, mixed directions
		for (int i = 0; i < 16; i++) begin
			rng_state = xorshift32(rng_state);
			operand   = rng_state;
			rng_state = xorshift32(rng_state);
			issue_op(shift_dir_t'(rng_state[0]), operand, {26'h0, rng_state[6:1]});
		end

		wait (checked_cnt == TOTAL_OPS);
		idle_cycle();
		if (exp_q.size() == 0 && issued_cnt == TOTAL_OPS) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			$display("operation count mismatch, issued %0d checked %0d",
				issued_cnt, checked_cnt);
			$display("*** FAILED ***");
			$fatal(1, "operation count mismatch");
		end
	end

endmodule
